// ==== filelist.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_victim_sel.sv
hw/icache_refill_wb.sv
hw/icache_top.sv
tests/tb_icache.sv

// ==== hw/icache_ctrl.sv ====
// instruction cache controller FSM, sequences flush, lookup, refill and the fetch response
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  fetch_req_t                fetch_req_i,
  input  logic                      hit_i,
  input  logic [`ICACHE_WORD_W-1:0] hit_word_i,
  input  logic                      refill_done_i,
  input  logic [LINE_W-1:0]         refill_line_i,
  input  logic [`ICACHE_WORD_W-1:0] refill_word_i,
  output logic                      ready_o,
  output fetch_rsp_t                fetch_rsp_o,
  output logic                      miss_o,
  output logic                      lookup_o,
  output logic [INDEX_W-1:0]        index_o,
  output logic [TAG_W-1:0]          tag_o,
  output logic                      flush_o,
  output logic [INDEX_W-1:0]        flush_set_o,
  output logic                      fill_o,
  output logic                      refill_start_o,
  output refill_kind_e              refill_kind_o,
  output logic [`ICACHE_ADDR_W-1:0] refill_addr_o
);

  ctrl_state_e               state_d, state_q;
  // address of the request in lookup or refill
  logic [`ICACHE_ADDR_W-1:0] addr_q;
  logic                      flush_d, flush_q;
  logic [INDEX_W-1:0]        flush_cnt_q;
  logic                      addr_nc;
  logic                      flush_done;
  logic [`ICACHE_WORD_W-1:0] line_word;

  ////////////////////
  // address split

  assign addr_nc    = addr_q[`ICACHE_NC_BIT];
  assign flush_done = (flush_cnt_q == INDEX_W'(`ICACHE_SETS - 1));

  // arrays are read with the incoming address, written with the latched one
  assign index_o = lookup_o ? fetch_req_i.addr[OFFSET_W +: INDEX_W]
                            : addr_q[OFFSET_W +: INDEX_W];
  assign tag_o   = addr_q[`ICACHE_ADDR_W-1 -: TAG_W];

  assign flush_set_o   = flush_cnt_q;
  assign refill_addr_o = addr_q;
  assign refill_kind_o = addr_nc ? REFILL_WORD : REFILL_LINE;

  // requested word out of the refilled line, fetches are word aligned
  assign line_word = refill_line_i[addr_q[OFFSET_W-1:2] * `ICACHE_WORD_W +: `ICACHE_WORD_W];

  ////////////////////
  // next state logic

  always_comb begin
    state_d        = state_q;
    flush_d        = flush_q | flush_i;
    ready_o        = 1'b0;
    lookup_o       = 1'b0;
    flush_o        = 1'b0;
    fill_o         = 1'b0;
    miss_o         = 1'b0;
    refill_start_o = 1'b0;
    fetch_rsp_o    = '0;

    unique case (state_q)
      // one set cleared per cycle, a pending flush is covered by this pass
      FLUSH: begin
        flush_o = 1'b1;
        flush_d = 1'b0;
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (flush_q) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (fetch_req_i.req) begin
            lookup_o = 1'b1;
            state_d  = LOOKUP;
          end
        end
      end
      // tag compare on the registered read, I/O addresses never hit
      LOOKUP: begin
        if (hit_i && !addr_nc) begin
          fetch_rsp_o.valid = 1'b1;
          fetch_rsp_o.data  = hit_word_i;
          if (flush_q) begin
            state_d = FLUSH;
          end else begin
            // keep accepting so that hits stream back to back
            ready_o = 1'b1;
            state_d = IDLE;
            if (fetch_req_i.req) begin
              lookup_o = 1'b1;
              state_d  = LOOKUP;
            end
          end
        end else begin
          miss_o         = !addr_nc;
          refill_start_o = 1'b1;
          state_d        = REFILL;
        end
      end
      // bus latency is open ended, just wait for done
      REFILL: begin
        if (refill_done_i) begin
          fetch_rsp_o.valid = 1'b1;
          fetch_rsp_o.data  = addr_nc ? refill_word_i : line_word;
          fill_o            = !addr_nc;
          state_d           = flush_q ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      // wraps to zero at the end of a pass
      if (flush_o) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      addr_q <= fetch_req_i.addr;
    end
  end

  // the refill master only answers the refill the FSM is waiting on
  refill_done_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_done_i |-> state_q == REFILL)
    else $error("icache_ctrl: refill done arrived outside the refill state");

endmodule

// ==== hw/icache_data_array.sv ====
// line storage per way, written on refill and read out as the word of the hitting way
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_data_array import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      lookup_i,
  input  logic [INDEX_W-1:0]        index_i,
  // word index within the line
  input  logic [OFFSET_W-3:0]       offset_i,
  input  logic                      fill_i,
  input  logic [WAY_IDX_W-1:0]      fill_way_i,
  input  logic [LINE_W-1:0]         fill_line_i,
  input  logic [WAY_IDX_W-1:0]      hit_way_i,
  output logic [`ICACHE_WORD_W-1:0] word_o
);

  logic [LINE_W-1:0]   line_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [LINE_W-1:0]   rd_line_q [`ICACHE_WAYS];
  logic [OFFSET_W-3:0] offset_q;
  logic [LINE_W-1:0]   sel_line;

  // whole line written into the victim way
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      line_mem[fill_way_i][index_i] <= fill_line_i;
    end
    // all ways read in parallel, way chosen after the tag compare
    if (lookup_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        rd_line_q[w] <= line_mem[w][index_i];
      end
      offset_q <= offset_i;
    end
  end

  assign sel_line = rd_line_q[hit_way_i];
  // word 0 sits in the low bits of the line
  assign word_o   = sel_line[offset_q * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

// ==== hw/icache_pkg.sv ====
// derived widths, port structs and enums shared by all instruction cache modules
`include "icache_settings.svh"

package icache_pkg;

  // address split: tag | index | byte offset
  localparam int OFFSET_W  = $clog2(`ICACHE_LINE_WORDS * `ICACHE_WORD_W / 8);
  localparam int INDEX_W   = $clog2(`ICACHE_SETS);
  localparam int TAG_W     = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_IDX_W = (`ICACHE_WAYS > 1) ? $clog2(`ICACHE_WAYS) : 1;
  localparam int LINE_W    = `ICACHE_LINE_WORDS * `ICACHE_WORD_W;

  // fetch port, request side
  typedef struct packed {
    logic                      req;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  // fetch port, response side
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_WORD_W-1:0] data;
  } fetch_rsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`ICACHE_ADDR_W-1:0] adr;
  } wb_m2s_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic                      ack;
    logic [`ICACHE_WORD_W-1:0] dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {FLUSH, IDLE, LOOKUP, REFILL} ctrl_state_e;

  // full line for cacheable misses, single word for I/O fetches
  typedef enum logic {REFILL_LINE, REFILL_WORD} refill_kind_e;

endpackage

// ==== hw/icache_refill_wb.sv ====
// wishbone classic read master, fetches a full line or a single word for the cache
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_refill_wb import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  refill_kind_e              kind_i,
  input  logic [`ICACHE_ADDR_W-1:0] addr_i,
  input  wb_s2m_t                   wb_i,
  output wb_m2s_t                   wb_o,
  output logic                      done_o,
  output logic [LINE_W-1:0]         line_o,
  output logic [`ICACHE_WORD_W-1:0] word_o
);

  localparam int BEAT_W = $clog2(`ICACHE_LINE_WORDS);

  logic                      busy_q, stb_q, done_q;
  refill_kind_e              kind_q;
  logic [BEAT_W-1:0]         beat_q;
  logic [`ICACHE_ADDR_W-1:0] adr_q;
  logic [LINE_W-1:0]         line_q;
  logic [`ICACHE_WORD_W-1:0] word_q;
  logic                      beat_ack, last_ack;

  assign beat_ack = stb_q & wb_i.ack;
  assign last_ack = beat_ack & ((kind_q == REFILL_WORD) ||
                                (beat_q == BEAT_W'(`ICACHE_LINE_WORDS - 1)));

  ////////////////////
  // bus sequencing

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      stb_q  <= 1'b0;
      done_q <= 1'b0;
      kind_q <= REFILL_LINE;
      beat_q <= '0;
    end else begin
      done_q <= last_ack;
      if (start_i) begin
        busy_q <= 1'b1;
        stb_q  <= 1'b1;
        kind_q <= kind_i;
        beat_q <= '0;
      end else if (beat_ack) begin
        // idle cycle between beats
        stb_q  <= 1'b0;
        beat_q <= beat_q + 1'b1;
        if (last_ack) begin
          busy_q <= 1'b0;
        end
      end else if (busy_q) begin
        stb_q <= 1'b1;
      end
    end
  end

  // line refills start aligned to the line, I/O reads to the word
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_q <= (kind_i == REFILL_LINE) ? {addr_i[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                                       : {addr_i[`ICACHE_ADDR_W-1:2], 2'b00};
    end else if (beat_ack) begin
      adr_q  <= adr_q + `ICACHE_ADDR_W'(`ICACHE_WORD_W / 8);
      line_q[beat_q * `ICACHE_WORD_W +: `ICACHE_WORD_W] <= wb_i.dat;
      word_q <= wb_i.dat;
    end
  end

  // read only master, cyc follows stb
  assign wb_o.cyc = stb_q;
  assign wb_o.stb = stb_q;
  assign wb_o.we  = 1'b0;
  assign wb_o.adr = adr_q;

  assign done_o = done_q;
  assign line_o = line_q;
  assign word_o = word_q;

  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr))
    else $error("icache_refill_wb: strobe or address changed before ack");

endmodule

// ==== hw/icache_settings.svh ====
// cache geometry and address split, included by the package and by every RTL file
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 32

// width of one fetched instruction word
`define ICACHE_WORD_W 32

// associativity
`define ICACHE_WAYS 2

// number of sets, power of two
`define ICACHE_SETS 16

// words per cache line, also the number of bus beats per refill
`define ICACHE_LINE_WORDS 4

// upper half of the address space is I/O, read uncached
`define ICACHE_NC_BIT 31

`endif

// ==== hw/icache_tag_array.sv ====
// tag and valid storage per way and set, with flush clear, fill write and hit detection
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_tag_array import icache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lookup_i,
  input  logic [INDEX_W-1:0]      index_i,
  input  logic [TAG_W-1:0]        tag_i,
  input  logic                    flush_i,
  input  logic [INDEX_W-1:0]      flush_set_i,
  input  logic                    fill_i,
  input  logic [WAY_IDX_W-1:0]    fill_way_i,
  output logic                    hit_o,
  output logic [WAY_IDX_W-1:0]    hit_way_o,
  output logic [`ICACHE_WAYS-1:0] valid_o
);

  logic [TAG_W-1:0]                          tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
  // read port registers, one per way
  logic [TAG_W-1:0]                          rd_tag_q [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]                   rd_valid_q;
  logic [`ICACHE_WAYS-1:0]                   hit_vec;

  // tag write on fill, the read returns the old content
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_mem[fill_way_i][index_i] <= tag_i;
    end
    if (lookup_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        rd_tag_q[w] <= tag_mem[w][index_i];
      end
    end
  end

  // valid bits, flush clears every way of one set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_q <= '0;
    end else begin
      if (flush_i) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          valid_q[w][flush_set_i] <= 1'b0;
        end
      end else if (fill_i) begin
        valid_q[fill_way_i][index_i] <= 1'b1;
      end
      if (lookup_i) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          rd_valid_q[w] <= valid_q[w][index_i];
        end
      end
    end
  end

  ////////////////////
  // hit detection

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
    assign hit_vec[w] = rd_valid_q[w] & (rd_tag_q[w] == tag_i);
  end

  // lowest hitting way wins
  always_comb begin
    hit_way_o = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = WAY_IDX_W'(w);
      end
    end
  end

  assign hit_o   = |hit_vec;
  assign valid_o = rd_valid_q;

  // a line is never allocated twice, which needs ctrl and victim select to agree
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_vec))
    else $error("icache_tag_array: line present in more than one way");

endmodule

// ==== hw/icache_top.sv ====
// two way instruction cache top, fetch port in front and a wishbone master for refills
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  fetch_req_t fetch_req_i,
  input  wb_s2m_t    wb_i,
  output logic       ready_o,
  output fetch_rsp_t fetch_rsp_o,
  output logic       miss_o,
  output wb_m2s_t    wb_o
);

  // array control from the controller
  logic                      lookup;
  logic [INDEX_W-1:0]        index;
  logic [TAG_W-1:0]          tag;
  logic                      flush;
  logic [INDEX_W-1:0]        flush_set;
  logic                      fill;
  // array results
  logic                      hit;
  logic [WAY_IDX_W-1:0]      hit_way;
  logic [`ICACHE_WAYS-1:0]   valid;
  logic [WAY_IDX_W-1:0]      victim_way;
  logic [`ICACHE_WORD_W-1:0] hit_word;
  // refill handshake
  logic                      refill_start;
  refill_kind_e              refill_kind;
  logic [`ICACHE_ADDR_W-1:0] refill_addr;
  logic                      refill_done;
  logic [LINE_W-1:0]         refill_line;
  logic [`ICACHE_WORD_W-1:0] refill_word;

  icache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .hit_i          (hit),
    .hit_word_i     (hit_word),
    .refill_done_i  (refill_done),
    .refill_line_i  (refill_line),
    .refill_word_i  (refill_word),
    .ready_o        (ready_o),
    .fetch_rsp_o    (fetch_rsp_o),
    .miss_o         (miss_o),
    .lookup_o       (lookup),
    .index_o        (index),
    .tag_o          (tag),
    .flush_o        (flush),
    .flush_set_o    (flush_set),
    .fill_o         (fill),
    .refill_start_o (refill_start),
    .refill_kind_o  (refill_kind),
    .refill_addr_o  (refill_addr)
  );

  icache_tag_array i_tag_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_i    (lookup),
    .index_i     (index),
    .tag_i       (tag),
    .flush_i     (flush),
    .flush_set_i (flush_set),
    .fill_i      (fill),
    .fill_way_i  (victim_way),
    .hit_o       (hit),
    .hit_way_o   (hit_way),
    .valid_o     (valid)
  );

  // offset comes straight from the request, latched in the array on lookup
  icache_data_array i_data_array (
    .clk_i       (clk_i),
    .lookup_i    (lookup),
    .index_i     (index),
    .offset_i    (fetch_req_i.addr[OFFSET_W-1:2]),
    .fill_i      (fill),
    .fill_way_i  (victim_way),
    .fill_line_i (refill_line),
    .hit_way_i   (hit_way),
    .word_o      (hit_word)
  );

  icache_victim_sel i_victim_sel (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (valid),
    .advance_i (fill),
    .way_o     (victim_way)
  );

  icache_refill_wb i_refill_wb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (refill_start),
    .kind_i  (refill_kind),
    .addr_i  (refill_addr),
    .wb_i    (wb_i),
    .wb_o    (wb_o),
    .done_o  (refill_done),
    .line_o  (refill_line),
    .word_o  (refill_word)
  );

endmodule

// ==== hw/icache_victim_sel.sv ====
// replacement way select, first invalid way or a pseudo random way once the set is full
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_victim_sel import icache_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`ICACHE_WAYS-1:0] valid_i,
  input  logic                    advance_i,
  output logic [WAY_IDX_W-1:0]    way_o
);

  // x^4 + x^3 + 1, maximal length
  localparam int LFSR_W = 4;

  logic [LFSR_W-1:0]    lfsr_q;
  logic [WAY_IDX_W-1:0] inv_way;
  logic                 all_valid;

  assign all_valid = &valid_i;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = WAY_IDX_W'(w);
      end
    end
  end

  // only steps when a full set actually gets a line replaced
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_W'(1);
    end else if (advance_i && all_valid) begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[LFSR_W-1] ^ lfsr_q[LFSR_W-2]};
    end
  end

  assign way_o = all_valid ? lfsr_q[WAY_IDX_W-1:0] : inv_way;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_icache \
  -f filelist.f

./obj_dir/Vtb_icache | tee sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== tests/tb_icache.sv ====
// testbench for the instruction cache top, drives fetches against a wishbone memory model
`timescale 1ns/100ps
`include "icache_settings.svh"

module tb_icache import icache_pkg::*; ();

  localparam int REQ_TIMEOUT   = 100;
  localparam int RSP_TIMEOUT   = 100;
  localparam int READY_TIMEOUT = 100;

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  fetch_req_t fetch_req;
  wb_s2m_t    wb_s2m = '0;
  logic       ready_o;
  fetch_rsp_t fetch_rsp;
  logic       miss_o;
  wb_m2s_t    wb_m2s;

  // stimulus side bookkeeping
  logic        expect_hit;
  logic        check_stb;
  int          sent_cnt;
  int          exp_miss;
  int          exp_ack;
  // observed side, updated on the rising edge
  logic        accept;
  logic        acc_q;
  int          rsp_cnt_q;
  int          miss_cnt_q;
  int          ack_cnt_q;
  logic [7:0]  since_rst_q;
  // outstanding accepted requests, oldest at head
  logic [31:0] pend_addr [8];
  logic [2:0]  head_q, tail_q;
  logic [31:0] exp_word;
  // memory model state
  logic [31:0] rng_q;
  logic [1:0]  ack_delay;
  logic        slave_busy;

  icache_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .fetch_req_i (fetch_req),
    .wb_i        (wb_s2m),
    .ready_o     (ready_o),
    .fetch_rsp_o (fetch_rsp),
    .miss_o      (miss_o),
    .wb_o        (wb_m2s)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers

  // memory content, word address xor a constant, rotated left by 3
  function automatic logic [31:0] model_word(input logic [31:0] byte_addr);
    logic [31:0] w;
    w = {2'b00, byte_addr[31:2]} ^ 32'h5A5A_0000;
    return {w[28:0], w[31:29]};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  ////////////////////
  // wishbone slave model

  // ack after 0 to 3 extra cycles, dropped again on the next falling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      wb_s2m     = '0;
      rng_q      = 32'd19;
      ack_delay  = 2'd0;
      slave_busy = 1'b0;
    end else if (wb_s2m.ack) begin
      wb_s2m.ack = 1'b0;
      slave_busy = 1'b0;
    end else if (wb_m2s.cyc && wb_m2s.stb) begin
      if (!slave_busy) begin
        rng_q      = xorshift32(rng_q);
        ack_delay  = rng_q[1:0];
        slave_busy = 1'b1;
      end
      if (ack_delay == 2'd0) begin
        wb_s2m.ack = 1'b1;
        wb_s2m.dat = model_word(wb_m2s.adr);
      end else begin
        ack_delay = ack_delay - 2'd1;
      end
    end
  end

  ////////////////////
  // monitors

  assign accept   = fetch_req.req & ready_o;
  assign exp_word = model_word(pend_addr[head_q]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= 1'b0;
      rsp_cnt_q   <= 0;
      miss_cnt_q  <= 0;
      ack_cnt_q   <= 0;
      head_q      <= '0;
      tail_q      <= '0;
      since_rst_q <= '0;
    end else begin
      acc_q <= accept;
      if (accept) begin
        tail_q <= tail_q + 3'd1;
      end
      if (fetch_rsp.valid) begin
        head_q    <= head_q + 3'd1;
        rsp_cnt_q <= rsp_cnt_q + 1;
      end
      if (miss_o) begin
        miss_cnt_q <= miss_cnt_q + 1;
      end
      if (wb_m2s.cyc && wb_m2s.stb && wb_s2m.ack) begin
        ack_cnt_q <= ack_cnt_q + 1;
      end
      // saturates just past the end of the first flush
      if (since_rst_q != 8'(`ICACHE_SETS + 1)) begin
        since_rst_q <= since_rst_q + 8'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pend_addr[tail_q] <= fetch_req.addr;
    end
  end

  ////////////////////
  // checks

  quiet_in_reset: assert property (@(posedge clk_i)
    (!rst_ni || since_rst_q < 8'(`ICACHE_SETS)) |->
      !ready_o && !fetch_rsp.valid && !wb_m2s.cyc && !wb_m2s.stb && !miss_o)
    else stop_on_error("ready, valid, miss or a bus strobe was high during reset or flush");

  ready_after_flush: assert property (@(posedge clk_i)
    (rst_ni && since_rst_q == 8'(`ICACHE_SETS)) |-> ready_o)
    else stop_on_error("ready did not rise when the flush after reset ended");

  rsp_has_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp.valid |-> head_q != tail_q)
    else stop_on_error("a response arrived with no request outstanding");

  rsp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp.valid |-> fetch_rsp.data == exp_word)
    else stop_on_error($sformatf("Mismatch fetch_rsp.data: got 0x%08h, expected 0x%08h",
                                 $sampled(fetch_rsp.data), $sampled(exp_word)));

  // hits answer on the very next edge
  hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && expect_hit |=> fetch_rsp.valid)
    else stop_on_error("a fetch that should hit gave no response one cycle after acceptance");

  hit_no_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && expect_hit |=> !miss_o)
    else stop_on_error("a fetch that should hit raised a miss");

  // a refill would raise the strobe on the cycle after the lookup
  hit_no_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(accept && expect_hit, 2) |-> !wb_m2s.cyc)
    else stop_on_error("a fetch that should hit started a bus cycle");

  wb_read_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_m2s.cyc |-> !wb_m2s.we)
    else stop_on_error("the cache issued a wishbone write");

  miss_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> miss_cnt_q == exp_miss)
    else stop_on_error($sformatf("Mismatch miss_o pulse count: got 0x%0h, expected 0x%0h",
                                 $sampled(miss_cnt_q), $sampled(exp_miss)));

  ack_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_stb |-> ack_cnt_q == exp_ack)
    else stop_on_error($sformatf("Mismatch wb ack count: got 0x%0h, expected 0x%0h",
                                 $sampled(ack_cnt_q), $sampled(exp_ack)));

  ////////////////////
  // stimulus tasks, each starts and ends on a falling edge

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!ready_o) begin
      if (waited == READY_TIMEOUT) stop_on_error("ready never rose after reset");
      @(negedge clk_i);
      waited++;
    end
  endtask

  // holds the request until the edge that accepts it has passed
  task automatic issue_req(input logic [31:0] addr, input logic hit);
    int waited;
    fetch_req.req  = 1'b1;
    fetch_req.addr = addr;
    expect_hit     = hit;
    waited         = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > REQ_TIMEOUT) stop_on_error("a fetch request was never accepted");
    end while (!acc_q);
    sent_cnt++;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (rsp_cnt_q != sent_cnt) begin
      if (waited == RSP_TIMEOUT) stop_on_error("timed out waiting for a fetch response");
      @(negedge clk_i);
      waited++;
    end
  endtask

  task automatic check_counts(input int misses, input int acks);
    exp_miss  = exp_miss + misses;
    exp_ack   = exp_ack + acks;
    check_stb = 1'b1;
    @(negedge clk_i);
    check_stb = 1'b0;
  endtask

  task automatic fetch_one(input logic [31:0] addr, input logic hit,
                           input int misses, input int acks);
    issue_req(addr, hit);
    fetch_req.req = 1'b0;
    expect_hit    = 1'b0;
    wait_responses();
    check_counts(misses, acks);
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  ////////////////////
  // main sequence

  initial begin
    rst_ni    = 1'b0;
    flush_i   = 1'b0;
    fetch_req = '0;
    expect_hit = 1'b0;
    check_stb = 1'b0;
    sent_cnt  = 0;
    exp_miss  = 0;
    exp_ack   = 0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_ready();

    // first touch of line A misses, every word then hits
    fetch_one(32'h0000_1048, 1'b0, 1, 4);
    fetch_one(32'h0000_1040, 1'b1, 0, 0);
    fetch_one(32'h0000_1044, 1'b1, 0, 0);
    fetch_one(32'h0000_104C, 1'b1, 0, 0);

    // back to back hits, one accepted per cycle
    issue_req(32'h0000_1040, 1'b1);
    issue_req(32'h0000_1044, 1'b1);
    issue_req(32'h0000_1048, 1'b1);
    issue_req(32'h0000_104C, 1'b1);
    fetch_req.req = 1'b0;
    expect_hit    = 1'b0;
    wait_responses();
    check_counts(0, 0);

    // I/O space, single word and never allocated
    fetch_one(32'h8000_1044, 1'b0, 0, 1);
    fetch_one(32'h8000_1044, 1'b0, 0, 1);
    fetch_one(32'h8000_0208, 1'b0, 0, 1);

    // B shares set 4 with A and takes the free way
    fetch_one(32'h0000_2044, 1'b0, 1, 4);
    fetch_one(32'h0000_1044, 1'b1, 0, 0);
    fetch_one(32'h0000_2048, 1'b1, 0, 0);
    // C replaces one of them
    fetch_one(32'h0000_304C, 1'b0, 1, 4);
    fetch_one(32'h0000_3040, 1'b1, 0, 0);

    // D is lost by the flush
    fetch_one(32'h0000_0100, 1'b0, 1, 4);
    fetch_one(32'h0000_0104, 1'b1, 0, 0);
    pulse_flush();
    fetch_one(32'h0000_0104, 1'b0, 1, 4);
    fetch_one(32'h0000_0108, 1'b1, 0, 0);
    fetch_one(32'h0000_3044, 1'b0, 1, 4);

    $display("All tests passed");
    $finish;
  end

endmodule
